// ==== hdl/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// **********************************************************
// Core address map
// **********************************************************

// PC value loaded while reset is high
`define CPU_RESET_VECTOR 16'h0000

// First interrupt vector
// Vector n sits at base + 4*n
`define CPU_IRQ_BASE 16'h0010

// Upper address byte of every LD and ST
`define CPU_IO_PAGE 8'h10

`endif

// ==== hdl/cpuPkg.sv ====
package cpuPkg;

    // **********************************************************
    // Opcodes in instruction bits 3:0
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        MOV  = 4'h5,    // Last register form
        ADDI = 4'h6,
        LDI  = 4'h7,
        LD   = 4'h8,
        ST   = 4'h9,
        JMP  = 4'hA,
        BRZ  = 4'hB,    // Last immediate form
        EI   = 4'hC,
        DI   = 4'hD,
        RETI = 4'hE,
        NOP  = 4'hF
    } opcodeT;

    // One instruction word, two decodings
    typedef union packed {
        struct packed {
            logic [3:0] regA;
            logic [3:0] regB;
            logic [3:0] spare;
            opcodeT     opcode;
        } regForm;
        struct packed {
            logic [3:0] regA;
            logic [7:0] imm8;
            opcodeT     opcode;
        } immForm;
    } instrT;

    typedef struct packed {
        logic interruptEnable;
        logic negative;
        logic zero;
        logic carry;
    } flagsT;

    typedef enum logic [1:0] {
        PC_NEXT,
        PC_BRANCH,
        PC_VECTOR,
        PC_SAVED
    } pcSelT;

    // **********************************************************
    // Datapath controls
    typedef struct packed {
        logic   regWrite;
        logic   regSrcMem;  // Write data from dMemIOOut
        opcodeT aluOp;
        logic   useImm;
        logic   flagWrite;
        pcSelT  pcSel;
        logic   pcLoad;
        logic   savePc;
    } ctrlT;

endpackage

// ==== hdl/control.sv ====
module control (
    input  logic          clk,
    input  logic          reset_out,
    input  cpuPkg::instrT instr,
    input  cpuPkg::flagsT flags,
    input  logic [3:0]    interrupt,
    output cpuPkg::ctrlT  ctrl,
    output logic          iMemReadEnable,
    output logic          dMemIOReadEn,
    output logic          dMemIOWriteEn,
    output logic [3:0]    interruptClr
);
    import cpuPkg::*;

    typedef enum logic [2:0] {IDLE, FETCH, EXEC, LOAD, IRQ} stateT;

    stateT      state;
    stateT      nextState;
    opcodeT     op;
    logic [1:0] irqPick;    // Lowest pending line
    logic [1:0] irqWin;     // Line being serviced
    logic       irqShadow;  // Lets one instruction run after EI or RETI
    logic       irqTake;

    assign op = instr.regForm.opcode;

    // **********************************************************
    // Interrupt priority
    always_comb begin
        casez (interrupt)
            4'b???1: irqPick = 2'd0;
            4'b??10: irqPick = 2'd1;
            4'b?100: irqPick = 2'd2;
            default: irqPick = 2'd3;
        endcase
    end

    assign irqTake = (state == FETCH) && flags.interruptEnable && (|interrupt) && !irqShadow;

    always_ff @(posedge clk) begin
        if (reset_out) begin
            state     <= IDLE;
            irqWin    <= 2'd0;
            irqShadow <= 1'b0;
        end else begin
            state <= nextState;
            if (irqTake)
                irqWin <= irqPick;
            if (state == EXEC && (op == EI || op == RETI))
                irqShadow <= 1'b1;
            else if (state == FETCH && !irqTake)
                irqShadow <= 1'b0;      // Shadowed instruction now fetched
        end
    end

    // **********************************************************
    // State sequencing and decode
    always_comb begin
        ctrl           = '0;
        ctrl.aluOp     = NOP;
        ctrl.pcSel     = PC_NEXT;
        iMemReadEnable = 1'b0;
        dMemIOReadEn   = 1'b0;
        dMemIOWriteEn  = 1'b0;
        interruptClr   = 4'b0000;
        nextState      = state;
        case (state)
            IDLE: nextState = FETCH;
            FETCH: begin
                if (irqTake) begin
                    nextState = IRQ;        // No fetch this cycle
                end else begin
                    iMemReadEnable = 1'b1;
                    ctrl.pcLoad    = 1'b1;  // PC steps past the fetched word
                    nextState      = EXEC;
                end
            end
            EXEC: begin
                ctrl.aluOp = op;
                nextState  = FETCH;
                case (op)
                    ADD, SUB, AND, OR, XOR: begin
                        ctrl.regWrite  = 1'b1;
                        ctrl.flagWrite = 1'b1;
                    end
                    MOV: ctrl.regWrite = 1'b1;
                    ADDI: begin
                        ctrl.regWrite  = 1'b1;
                        ctrl.useImm    = 1'b1;
                        ctrl.flagWrite = 1'b1;
                    end
                    LDI: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.useImm   = 1'b1;
                    end
                    LD: begin
                        dMemIOReadEn = 1'b1;
                        nextState    = LOAD;
                    end
                    ST: dMemIOWriteEn = 1'b1;
                    JMP: begin
                        ctrl.pcSel  = PC_BRANCH;
                        ctrl.pcLoad = 1'b1;
                    end
                    BRZ: begin
                        ctrl.pcSel  = PC_BRANCH;
                        ctrl.pcLoad = flags.zero;   // Taken on zero only
                    end
                    RETI: begin
                        ctrl.pcSel  = PC_SAVED;
                        ctrl.pcLoad = 1'b1;
                    end
                    default: ;                      // EI, DI and NOP
                endcase
            end
            LOAD: begin
                ctrl.aluOp     = op;
                ctrl.regWrite  = 1'b1;
                ctrl.regSrcMem = 1'b1;
                nextState      = FETCH;
            end
            IRQ: begin
                ctrl.savePc  = 1'b1;
                ctrl.pcSel   = PC_VECTOR;
                ctrl.pcLoad  = 1'b1;
                interruptClr = 4'b0001 << irqWin;
                nextState    = FETCH;
            end
            default: nextState = IDLE;
        endcase
    end

endmodule

// ==== hdl/regFile.sv ====
module regFile (
    input  logic       clk,
    input  logic       reset_out,
    input  logic [3:0] readA,
    input  logic [3:0] readB,
    input  logic       writeEnable,
    input  logic [7:0] writeData,
    output logic [7:0] outA,
    output logic [7:0] outB
);

    // **********************************************************
    // Sixteen 8-bit registers
    logic [7:0] regs [16];

    always_ff @(posedge clk) begin
        if (reset_out) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (writeEnable) begin
            regs[readA] <= writeData;   // Destination is always register A
        end
    end

    // **********************************************************
    // Asynchronous read ports

    // Register A feeds the ALU and the data-memory write data
    assign outA = regs[readA];

    // Register B is the second ALU operand
    assign outB = regs[readB];

endmodule

// ==== hdl/alu.sv ====
module alu (
    input  logic          clk,
    input  logic          reset_out,
    input  cpuPkg::ctrlT  ctrl,
    input  logic [7:0]    dataA,
    input  logic [7:0]    dataB,
    input  logic [7:0]    imm8,
    output logic [7:0]    result,
    output cpuPkg::flagsT flags,
    input  logic          setIe,
    input  logic          clearIe
);
    import cpuPkg::*;

    logic [7:0] operandB;
    logic [8:0] wide;       // Result with carry or borrow on top

    assign operandB = ctrl.useImm ? imm8 : dataB;

    // **********************************************************
    // Operations
    always_comb begin
        case (ctrl.aluOp)
            ADD, ADDI: wide = {1'b0, dataA} + {1'b0, operandB};
            SUB:       wide = {1'b0, dataA} - {1'b0, operandB};  // Bit 8 is the borrow
            AND:       wide = {1'b0, dataA & operandB};
            OR:        wide = {1'b0, dataA | operandB};
            XOR:       wide = {1'b0, dataA ^ operandB};
            default:   wide = {1'b0, operandB};     // MOV and LDI pass B through
        endcase
    end

    assign result = wide[7:0];

    // **********************************************************
    // Status register
    always_ff @(posedge clk) begin
        if (reset_out) begin
            flags <= '0;
        end else begin
            if (ctrl.flagWrite) begin
                flags.carry    <= wide[8];      // Logic ops clear it
                flags.zero     <= (wide[7:0] == 8'h00);
                flags.negative <= wide[7];
            end
            if (clearIe)
                flags.interruptEnable <= 1'b0;
            else if (setIe)
                flags.interruptEnable <= 1'b1;
        end
    end

endmodule

// ==== hdl/programCounter.sv ====
`include "cpu_cfg.svh"

module programCounter (
    input  logic         clk,
    input  logic         reset_out,
    input  cpuPkg::ctrlT ctrl,
    input  logic [7:0]   imm8,
    input  logic [1:0]   irqIndex,
    output logic [15:0]  iMemAddress
);
    import cpuPkg::*;

    logic [15:0] pc;
    logic [15:0] curAddr;   // Address of the instruction in EXEC
    logic [15:0] savedPc;   // Return address for RETI
    logic [15:0] target;
    logic [15:0] pcIn;

    // **********************************************************
    // Branch target
    always_comb begin
        if (ctrl.aluOp == BRZ)
            target = curAddr + {{8{imm8[7]}}, imm8};    // Signed offset
        else
            target = {8'h00, imm8};                     // JMP
    end

    // Next PC select
    always_comb begin
        case (ctrl.pcSel)
            PC_NEXT:   pcIn = pc + 16'd1;
            PC_BRANCH: pcIn = target;
            PC_VECTOR: pcIn = `CPU_IRQ_BASE + {12'd0, irqIndex, 2'b00};
            default:   pcIn = savedPc;
        endcase
    end

    // **********************************************************
    // Registers
    always_ff @(posedge clk) begin
        if (reset_out)
            pc <= `CPU_RESET_VECTOR;
        else if (ctrl.pcLoad)
            pc <= pcIn;
    end

    always_ff @(posedge clk) begin
        if (ctrl.pcLoad && ctrl.pcSel == PC_NEXT)
            curAddr <= pc;      // Fetch in progress
        if (ctrl.savePc)
            savedPc <= pc;      // PC of the instruction not yet fetched
    end

    assign iMemAddress = pc;

endmodule

// ==== hdl/cpu.sv ====
`include "cpu_cfg.svh"

module cpu (
    input  logic        clk,
    input  logic        reset_out,
    output logic [15:0] iMemAddress,
    input  logic [15:0] iMemOut,
    output logic        iMemReadEnable,
    output logic [15:0] dMemIOAddress,
    output logic [7:0]  dMemIOIn,
    input  logic [7:0]  dMemIOOut,
    output logic        dMemIOWriteEn,
    output logic        dMemIOReadEn,
    input  logic [3:0]  interrupt,
    output logic [3:0]  interruptClr
);
    import cpuPkg::*;

    instrT      instr;
    ctrlT       ctrl;
    flagsT      flags;
    logic [7:0] regOutA;
    logic [7:0] regOutB;
    logic [7:0] regIn;
    logic [7:0] aluResult;
    logic [1:0] irqIndex;
    logic       setIe;
    logic       clearIe;

    assign instr = iMemOut;

    // **********************************************************
    // Control
    control controlInst (
        .clk            (clk),
        .reset_out      (reset_out),
        .instr          (instr),
        .flags          (flags),
        .interrupt      (interrupt),
        .ctrl           (ctrl),
        .iMemReadEnable (iMemReadEnable),
        .dMemIOReadEn   (dMemIOReadEn),
        .dMemIOWriteEn  (dMemIOWriteEn),
        .interruptClr   (interruptClr)
    );

    // Vector number from the one-hot clear pulse
    always_comb begin
        case (interruptClr)
            4'b0010: irqIndex = 2'd1;
            4'b0100: irqIndex = 2'd2;
            4'b1000: irqIndex = 2'd3;
            default: irqIndex = 2'd0;
        endcase
    end

    assign setIe   = (ctrl.aluOp == EI) || (ctrl.aluOp == RETI);
    assign clearIe = (ctrl.aluOp == DI) || ctrl.savePc;    // DI or interrupt entry

    // **********************************************************
    // Datapath
    assign regIn = ctrl.regSrcMem ? dMemIOOut : aluResult;

    regFile regFileInst (
        .clk         (clk),
        .reset_out   (reset_out),
        .readA       (instr.regForm.regA),
        .readB       (instr.regForm.regB),
        .writeEnable (ctrl.regWrite),
        .writeData   (regIn),
        .outA        (regOutA),
        .outB        (regOutB)
    );

    alu aluInst (
        .clk       (clk),
        .reset_out (reset_out),
        .ctrl      (ctrl),
        .dataA     (regOutA),
        .dataB     (regOutB),
        .imm8      (instr.immForm.imm8),
        .result    (aluResult),
        .flags     (flags),
        .setIe     (setIe),
        .clearIe   (clearIe)
    );

    programCounter pcInst (
        .clk         (clk),
        .reset_out   (reset_out),
        .ctrl        (ctrl),
        .imm8        (instr.immForm.imm8),
        .irqIndex    (irqIndex),
        .iMemAddress (iMemAddress)
    );

    // IO page access, data from register A
    assign dMemIOAddress = {`CPU_IO_PAGE, instr.immForm.imm8};
    assign dMemIOIn      = regOutA;

endmodule

// ==== bench/clockGen.sv ====
module clockGen (
    output logic clk,
    output logic reset_out
);

    // Period of 100 time units
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Power-on reset for the first four cycles
    initial begin
        reset_out = 1'b1;
        repeat (4) @(posedge clk);
        reset_out <= 1'b0;
    end

endmodule

// ==== bench/cpu_assertions.sv ====
module cpu_assertions (
    input logic       clk,
    input logic       reset_out,
    input logic       iMemReadEnable,
    input logic       dMemIOReadEn,
    input logic       dMemIOWriteEn,
    input logic [3:0] interruptClr
);

    // Data memory is either read or written, never both
    strobeExclusive: assert property (@(posedge clk) disable iff (reset_out)
        !(dMemIOReadEn && dMemIOWriteEn))
        else $error("data read and write strobes high together");

    clearOneCycle: assert property (@(posedge clk) disable iff (reset_out)
        (interruptClr != 4'b0000) |=> (interruptClr == 4'b0000))
        else $error("interrupt clear held longer than one cycle");

    // Fetch cycles carry no data access
    fetchAlone: assert property (@(posedge clk) disable iff (reset_out)
        iMemReadEnable |-> !(dMemIOReadEn || dMemIOWriteEn))
        else $error("instruction fetch together with a data strobe");

endmodule

bind cpu cpu_assertions cpuChecks (
    .clk            (clk),
    .reset_out      (reset_out),
    .iMemReadEnable (iMemReadEnable),
    .dMemIOReadEn   (dMemIOReadEn),
    .dMemIOWriteEn  (dMemIOWriteEn),
    .interruptClr   (interruptClr)
);

// ==== bench/tb_cpu.sv ====
`include "cpu_cfg.svh"

module tb_cpu;
    import cpuPkg::*;

    localparam int PROGRAM_WORDS   = 67;   // All test programs together
    localparam int WATCHDOG_CYCLES = PROGRAM_WORDS * 4 + 300;
    localparam int WAIT_LIMIT      = 200;

    logic        clk;
    logic        porReset;
    logic        testReset;
    logic        reset_out;
    logic [15:0] iMemAddress;
    logic [15:0] iMemOut;
    logic        iMemReadEnable;
    logic [15:0] dMemIOAddress;
    logic [7:0]  dMemIOIn;
    logic [7:0]  dMemIOOut;
    logic        dMemIOWriteEn;
    logic        dMemIOReadEn;
    logic [3:0]  interrupt;
    logic [3:0]  interruptClr;

    logic [15:0] imem [65536];
    logic [7:0]  dmem [65536];
    logic [15:0] wrAddr [$];
    logic [7:0]  wrData [$];
    logic [15:0] fetchAddr [$];
    logic [3:0]  clrSeen [$];
    logic [31:0] lfsr = 32'hf648d4f9;
    int          errorCount = 0;

    assign reset_out = porReset | testReset;

    clockGen clockGenInst (.clk(clk), .reset_out(porReset));

    cpu cpu_inst (
        .clk(clk), .reset_out(reset_out),
        .iMemAddress(iMemAddress), .iMemOut(iMemOut), .iMemReadEnable(iMemReadEnable),
        .dMemIOAddress(dMemIOAddress), .dMemIOIn(dMemIOIn), .dMemIOOut(dMemIOOut),
        .dMemIOWriteEn(dMemIOWriteEn), .dMemIOReadEn(dMemIOReadEn),
        .interrupt(interrupt), .interruptClr(interruptClr)
    );

    // **********************************************************
    // Memory models and event recording
    always @(posedge clk) begin
        if (iMemReadEnable) begin
            iMemOut <= imem[iMemAddress];
            fetchAddr.push_back(iMemAddress);
        end
        if (dMemIOReadEn)
            dMemIOOut <= dmem[dMemIOAddress];
        if (dMemIOWriteEn) begin
            dmem[dMemIOAddress] <= dMemIOIn;
            wrAddr.push_back(dMemIOAddress);
            wrData.push_back(dMemIOIn);
        end
        if (interruptClr != 4'b0000) begin
            clrSeen.push_back(interruptClr);
            interrupt <= interrupt & ~interruptClr;     // Source drops on its clear
        end
    end

    // **********************************************************
    // Helpers
    function automatic logic [15:0] encReg(opcodeT op, logic [3:0] a, logic [3:0] b);
        instrT w;
        w.regForm.regA   = a;
        w.regForm.regB   = b;
        w.regForm.spare  = 4'h0;
        w.regForm.opcode = op;
        return w;
    endfunction

    function automatic logic [15:0] encImm(opcodeT op, logic [3:0] a, logic [7:0] imm);
        instrT w;
        w.immForm.regA   = a;
        w.immForm.imm8   = imm;
        w.immForm.opcode = op;
        return w;
    endfunction

    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // Taps 32 22 2 1
    endfunction

    function logic [7:0] randByte();
        logic [7:0] v;
        v = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsrNext(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic reportError(string msg);
        errorCount++;
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic checkByte(string name, logic [7:0] got, logic [7:0] exp);
        if (got !== exp)
            reportError($sformatf("** Error at %0t: %s is %02h, expected %02h",
                                  $time, name, got, exp));
    endtask

    task automatic checkAddr(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp)
            reportError($sformatf("** Error at %0t: %s is %04h, expected %04h",
                                  $time, name, got, exp));
    endtask

    task automatic checkLines(string name, logic [3:0] got, logic [3:0] exp);
        if (got !== exp)
            reportError($sformatf("** Error at %0t: %s is %04b, expected %04b",
                                  $time, name, got, exp));
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp)
            reportError($sformatf("** Error at %0t: %s is %b, expected %b",
                                  $time, name, got, exp));
    endtask

    task automatic checkQuiet();
        checkBit("iMemReadEnable", iMemReadEnable, 1'b0);
        checkBit("dMemIOReadEn", dMemIOReadEn, 1'b0);
        checkBit("dMemIOWriteEn", dMemIOWriteEn, 1'b0);
        checkLines("interruptClr", interruptClr, 4'b0000);
    endtask

    // Reset held four cycles with the strobes checked during it
    task automatic holdReset();
        @(posedge clk);
        testReset <= 1'b1;
        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            checkQuiet();
        end
        for (int i = 0; i < 65536; i++)
            imem[i] = {i[15:4] ^ i[11:0], 4'hF};     // NOP tagged with its address
    endtask

    task automatic releaseReset();
        @(posedge clk);
        testReset <= 1'b0;
        wrAddr.delete();
        wrData.delete();
        fetchAddr.delete();
        clrSeen.delete();
    endtask

    task automatic waitWrite(output logic [15:0] a, output logic [7:0] d);
        int n;
        n = 0;
        while (wrAddr.size() == 0) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                reportError("Expected data memory write never arrived");
        end
        a = wrAddr.pop_front();
        d = wrData.pop_front();
    endtask

    task automatic waitFetches(int count);
        int n;
        n = 0;
        while (fetchAddr.size() < count) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT)
                reportError("Instruction fetches stopped before the expected count");
        end
    endtask

    // **********************************************************
    // Directed tests
    task automatic testArith();
        opcodeT     ops [6];
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] exp;
        logic [15:0] addr;
        logic [7:0]  data;
        ops = '{ADD, SUB, AND, OR, XOR, MOV};
        a = randByte();
        b = randByte();
        holdReset();
        imem[0] = encImm(LDI, 4'd1, a);
        imem[1] = encImm(LDI, 4'd2, b);
        for (int i = 0; i < 6; i++) begin
            imem[2 + 3 * i] = encReg(MOV, 4'd3, 4'd1);
            imem[3 + 3 * i] = encReg(ops[i], 4'd3, 4'd2);
            imem[4 + 3 * i] = encImm(ST, 4'd3, 8'h20 + i[7:0]);
        end
        imem[20] = encImm(JMP, 4'd0, 8'd20);
        releaseReset();
        for (int i = 0; i < 6; i++) begin
            case (i)
                0: exp = a + b;
                1: exp = a - b;
                2: exp = a & b;
                3: exp = a | b;
                4: exp = a ^ b;
                default: exp = b;
            endcase
            waitWrite(addr, data);
            checkAddr("dMemIOAddress", addr, {`CPU_IO_PAGE, 8'h20 + i[7:0]});
            checkByte("dMemIOIn", data, exp);
        end
    endtask

    task automatic runFlags(logic [7:0] a, logic [7:0] b);
        logic [7:0]  sum;
        logic [15:0] addr;
        logic [7:0]  data;
        sum = a + b;
        holdReset();
        imem[0] = encImm(LDI, 4'd1, a);
        imem[1] = encImm(LDI, 4'd2, b);
        imem[2] = encReg(ADD, 4'd1, 4'd2);
        imem[3] = encImm(BRZ, 4'd0, 8'd2);
        imem[4] = encImm(ST, 4'd1, 8'h60);      // Marker for a nonzero sum
        imem[5] = encImm(ST, 4'd1, 8'h61);
        imem[6] = encImm(JMP, 4'd0, 8'd6);
        releaseReset();
        waitWrite(addr, data);
        checkAddr("dMemIOAddress", addr, {`CPU_IO_PAGE, (sum == 8'h00) ? 8'h61 : 8'h60});
        checkByte("dMemIOIn", data, sum);
    endtask

    task automatic testFlags();
        logic [7:0] a;
        a = randByte() | 8'h01;
        runFlags(a, -a);            // Carries out and leaves zero
        a = randByte();
        runFlags(a, 8'h01 - a);     // Sum of one
    endtask

    task automatic loadStoreProgram(logic [7:0] x);
        imem[0] = encImm(LDI, 4'd1, x);
        imem[1] = encImm(ST, 4'd1, 8'h30);
        imem[2] = encImm(LD, 4'd2, 8'h30);
        imem[3] = encImm(ST, 4'd2, 8'h31);
        imem[4] = encImm(JMP, 4'd0, 8'd4);
    endtask

    task automatic testLoadStore();
        logic [7:0]  x;
        logic [15:0] addr;
        logic [7:0]  data;
        x = randByte();
        holdReset();
        loadStoreProgram(x);
        releaseReset();
        waitWrite(addr, data);
        checkAddr("dMemIOAddress", addr, {`CPU_IO_PAGE, 8'h30});
        checkByte("dMemIOIn", data, x);
        waitWrite(addr, data);
        checkAddr("dMemIOAddress", addr, {`CPU_IO_PAGE, 8'h31});
        checkByte("dMemIOIn", data, x);
    endtask

    task automatic testFlow();
        logic [15:0] exp [8];
        logic [7:0]  off;
        logic [15:0] addr;
        logic [7:0]  data;
        off = 8'hFF;
        holdReset();
        imem[0]  = encImm(LDI, 4'd1, 8'hFF);
        imem[1]  = encImm(JMP, 4'd0, 8'h08);
        imem[8]  = encImm(ADDI, 4'd1, 8'h01);
        imem[9]  = encImm(BRZ, 4'd0, off);
        imem[10] = encImm(ST, 4'd1, 8'h40);
        imem[11] = encImm(JMP, 4'd0, 8'd11);
        releaseReset();
        exp = '{16'd0, 16'd1, 16'h0008, 16'd9, 16'h0008,   // Taken branch back to 8
                16'd9, 16'd10, 16'd11};
        waitFetches(8);
        for (int i = 0; i < 8; i++)
            checkAddr("iMemAddress", fetchAddr[i], exp[i]);
        waitWrite(addr, data);
        checkAddr("dMemIOAddress", addr, {`CPU_IO_PAGE, 8'h40});
        checkByte("dMemIOIn", data, 8'h01);
    endtask

    task automatic testInterrupts();
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  h;
        h = randByte();
        holdReset();
        imem[0] = encImm(LDI, 4'd1, 8'h11);
        imem[1] = encImm(LDI, 4'd3, h);
        imem[2] = encReg(EI, 4'd0, 4'd0);
        imem[3] = encReg(NOP, 4'd0, 4'd0);     // Runs before any interrupt
        imem[4] = encImm(ST, 4'd1, 8'h50);
        imem[5] = encImm(ST, 4'd1, 8'h51);
        imem[6] = encImm(JMP, 4'd0, 8'd6);
        imem[`CPU_IRQ_BASE + 4]     = encImm(ST, 4'd3, 8'hA1);
        imem[`CPU_IRQ_BASE + 5]     = encReg(RETI, 4'd0, 4'd0);
        imem[`CPU_IRQ_BASE + 8]     = encImm(ST, 4'd3, 8'hA2);
        imem[`CPU_IRQ_BASE + 9]     = encReg(RETI, 4'd0, 4'd0);
        releaseReset();
        waitFetches(4);
        @(posedge clk);
        interrupt <= 4'b0110;
        waitWrite(addr, data);
        checkLines("interruptClr", clrSeen[0], 4'b0010);
        checkAddr("iMemAddress", fetchAddr[4], `CPU_IRQ_BASE + 16'd4);
        checkAddr("dMemIOAddress", addr, {`CPU_IO_PAGE, 8'hA1});
        checkByte("dMemIOIn", data, h);
        waitWrite(addr, data);
        checkAddr("dMemIOAddress", addr, {`CPU_IO_PAGE, 8'h50});
        waitWrite(addr, data);
        checkLines("interruptClr", clrSeen[1], 4'b0100);
        checkAddr("dMemIOAddress", addr, {`CPU_IO_PAGE, 8'hA2});
        waitWrite(addr, data);
        checkAddr("dMemIOAddress", addr, {`CPU_IO_PAGE, 8'h51});
    endtask

    task automatic testRestart();
        logic [15:0] addr;
        logic [7:0]  data;
        holdReset();
        loadStoreProgram(randByte());
        releaseReset();
        waitFetches(1);
        checkAddr("iMemAddress", fetchAddr[0], `CPU_RESET_VECTOR);
        waitWrite(addr, data);
        checkAddr("dMemIOAddress", addr, {`CPU_IO_PAGE, 8'h30});
        holdReset();                // Hits the LD in progress
        loadStoreProgram(randByte());
        releaseReset();
        waitFetches(1);
        checkAddr("iMemAddress", fetchAddr[0], `CPU_RESET_VECTOR);
    endtask

    // **********************************************************
    // Sequence, watchdog and verdict
    initial begin
        testReset = 1'b0;
        interrupt = 4'b0000;
        iMemOut   = 16'h0000;
        dMemIOOut = 8'h00;
        for (int i = 0; i < 65536; i++)
            dmem[i] = i[15:8] ^ i[7:0] ^ 8'hA5;
        testArith();
        testFlags();
        testLoadStore();
        testFlow();
        testInterrupts();
        testRestart();
        if (errorCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 100);
        reportError("Watchdog expired before the tests finished");
    end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/cpuPkg.sv
hdl/control.sv
hdl/regFile.sv
hdl/alu.sv
hdl/programCounter.sv
hdl/cpu.sv
bench/clockGen.sv
bench/cpu_assertions.sv
bench/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - target: rtl
    include_dirs:
      - hdl
    files:
      - hdl/cpuPkg.sv
      - hdl/control.sv
      - hdl/regFile.sv
      - hdl/alu.sv
      - hdl/programCounter.sv
      - hdl/cpu.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/clockGen.sv
      - bench/cpu_assertions.sv
      - bench/tb_cpu.sv
